/* common/crc_pkg.sv */
`default_nettype none

package crc_pkg;

	// beat geometry
	localparam int BEAT_BYTES = 32;
	localparam int BEAT_BITS  = BEAT_BYTES * 8;
	localparam int CRC_BYTES  = 4;

	typedef logic [BEAT_BITS-1:0]   data_beat_t;
	typedef logic [CRC_BYTES*8-1:0] crc_t;
	typedef logic [7:0]             byte_t;
	typedef logic [4:0]             beat_tag_t;   // unused trailing bytes
	typedef logic [5:0]             byte_count_t; // 1..32 valid bytes

	// non-reflected crc-32, msb first
	localparam crc_t CRC_POLY = 32'h04C1_1DB7;
	localparam crc_t CRC_INIT = 32'hFFFF_FFFF;

	// r * x^8 mod poly
	function automatic crc_t crc_shift_byte(crc_t r);
		crc_t v;
		v = r;
		for (int b = 0; b < 8; b++) begin
			if (v[$bits(crc_t)-1])
				v = (v << 1) ^ CRC_POLY;
			else
				v = v << 1;
		end
		return v;
	endfunction

	// remainder of byte b sitting 8*d bits above the crc field,
	// i.e. b * x^(32 + 8d) mod poly
	// d runs 0 .. BEAT_BYTES-1; the loop is bounded so it unrolls to a fixed depth
	function automatic crc_t crc_fold_byte(byte_t b, int d);
		crc_t r;
		r = crc_t'(b) << (8 * (CRC_BYTES - 1)); // b * x^24, already reduced
		r = crc_shift_byte(r);                  // now b * x^32
		for (int i = 0; i < BEAT_BYTES; i++) begin
			if (i < d)
				r = crc_shift_byte(r);
		end
		return r;
	endfunction

endpackage

`default_nettype wire

/* hw/crc_beat_folder.sv */
`default_nettype none

module crc_beat_folder (
	input  wire logic                 i_clk,
	input  wire logic                 i_areset_n,
	input  wire crc_pkg::data_beat_t  i_data,
	input  wire crc_pkg::beat_tag_t   i_tag,
	input  wire logic                 i_sop,
	input  wire logic                 i_eop,
	output crc_pkg::crc_t             o_fold,
	output crc_pkg::byte_count_t      o_count,
	output logic                      o_sop,
	output logic                      o_eop,
	output crc_pkg::data_beat_t       o_data,
	output crc_pkg::beat_tag_t        o_tag
);

	crc_pkg::data_beat_t  s1_aligned;
	crc_pkg::byte_count_t s1_count;
	crc_pkg::byte_count_t s2_count;
	crc_pkg::crc_t        s2_terms [crc_pkg::BEAT_BYTES];
	crc_pkg::crc_t        s2_xor;
	crc_pkg::data_beat_t  s1_data;
	crc_pkg::data_beat_t  s2_data;
	crc_pkg::beat_tag_t   s1_tag;
	crc_pkg::beat_tag_t   s2_tag;
	logic                 s1_sop;
	logic                 s2_sop;
	logic                 s1_eop;
	logic                 s2_eop;

	// stage 1: drop the unused trailing bytes so the last valid byte lands at bit 0
	always_ff @(posedge i_clk) begin
		s1_aligned <= i_data >> {i_tag, 3'b000};
		s1_count   <= crc_pkg::byte_count_t'(crc_pkg::BEAT_BYTES - int'(i_tag));
	end

	// stage 2: byte p of the aligned beat is p bytes from the end
	always_ff @(posedge i_clk) begin
		for (int p = 0; p < crc_pkg::BEAT_BYTES; p++) begin
			s2_terms[p] <= crc_pkg::crc_fold_byte(s1_aligned[8*p +: 8], p);
		end
		s2_count <= s1_count;
	end

	always_comb begin
		s2_xor = '0;
		for (int p = 0; p < crc_pkg::BEAT_BYTES; p++) begin
			s2_xor ^= s2_terms[p]; // zero padding folds to zero
		end
	end

	// stage 3
	always_ff @(posedge i_clk) begin
		o_fold  <= s2_xor;
		o_count <= s2_count;
	end

	// untouched beat and tag ride along
	always_ff @(posedge i_clk) begin
		s1_data <= i_data;
		s2_data <= s1_data;
		o_data  <= s2_data;
		s1_tag  <= i_tag;
		s2_tag  <= s1_tag;
		o_tag   <= s2_tag;
	end

	always_ff @(posedge i_clk) begin
		if (!i_areset_n) begin
			s1_sop <= 1'b0;
			s2_sop <= 1'b0;
			o_sop  <= 1'b0;
			s1_eop <= 1'b0;
			s2_eop <= 1'b0;
			o_eop  <= 1'b0;
		end else begin
			s1_sop <= i_sop;
			s2_sop <= s1_sop;
			o_sop  <= s2_sop;
			s1_eop <= i_eop;
			s2_eop <= s1_eop;
			o_eop  <= s2_eop;
		end
	end

endmodule

`default_nettype wire

/* hw/crc_accumulator.sv */
`default_nettype none

module crc_accumulator (
	input  wire logic                 i_clk,
	input  wire logic                 i_areset_n,
	input  wire crc_pkg::crc_t        i_fold,
	input  wire crc_pkg::byte_count_t i_count,
	input  wire logic                 i_sop,
	input  wire logic                 i_eop,
	output logic                      o_tail_valid,
	output crc_pkg::crc_t             o_prev_state,
	output crc_pkg::crc_t             o_tail_fold,
	output crc_pkg::byte_count_t      o_tail_count
);

	localparam int ADV_BASE = crc_pkg::BEAT_BYTES - crc_pkg::CRC_BYTES;

	crc_pkg::crc_t state_q;
	crc_pkg::crc_t work_state;
	crc_pkg::crc_t work_adv;

	// restart at sop, otherwise continue from the running state
	always_comb begin
		work_state = i_sop ? crc_pkg::CRC_INIT : state_q;
	end

	// state pushed forward by one full beat of 32 bytes
	always_comb begin
		work_adv = '0;
		for (int k = 0; k < crc_pkg::CRC_BYTES; k++) begin
			work_adv ^= crc_pkg::crc_fold_byte(work_state[8*k +: 8], ADV_BASE + k);
		end
	end

	// single-cycle feedback loop
	always_ff @(posedge i_clk) begin
		if (!i_areset_n)
			state_q <= crc_pkg::CRC_INIT;
		else if (!i_eop)
			state_q <= work_adv ^ i_fold;
	end

	always_ff @(posedge i_clk) begin
		if (!i_areset_n)
			o_tail_valid <= 1'b0;
		else
			o_tail_valid <= i_eop; // one pulse per packet
	end

	// last beat is finished by the tail merge, which knows its byte count
	always_ff @(posedge i_clk) begin
		if (i_eop) begin
			o_prev_state <= work_state;
			o_tail_fold  <= i_fold;
			o_tail_count <= i_count;
		end
	end

endmodule

`default_nettype wire

/* hw/crc_tail_merge.sv */
`default_nettype none

module crc_tail_merge (
	input  wire logic                 i_clk,
	input  wire logic                 i_areset_n,
	input  wire logic                 i_tail_valid,
	input  wire crc_pkg::crc_t        i_prev_state,
	input  wire crc_pkg::crc_t        i_tail_fold,
	input  wire crc_pkg::byte_count_t i_tail_count,
	output crc_pkg::crc_t             o_crc,
	output logic                      o_crc_valid
);

	crc_pkg::crc_t term_c [crc_pkg::CRC_BYTES];
	crc_pkg::crc_t remainder_c;
	crc_pkg::crc_t term_q [crc_pkg::CRC_BYTES];
	crc_pkg::crc_t remainder_q;
	crc_pkg::crc_t fold_q;
	crc_pkg::crc_t merge_c;
	logic          valid_q;

	// state byte k advanced by n bytes lands at distance n + k - 4
	always_comb begin
		for (int k = 0; k < crc_pkg::CRC_BYTES; k++) begin
			if (int'(i_tail_count) + k >= crc_pkg::CRC_BYTES)
				term_c[k] = crc_pkg::crc_fold_byte(i_prev_state[8*k +: 8],
					int'(i_tail_count) + k - crc_pkg::CRC_BYTES);
			else
				term_c[k] = '0; // not past the crc field yet
		end
	end

	// for n < 4 the low state bytes only move up, no reduction needed
	// n >= 4 shifts everything out, so this is zero then
	always_comb begin
		remainder_c = i_prev_state << {i_tail_count, 3'b000};
	end

	// step 1
	always_ff @(posedge i_clk) begin
		for (int k = 0; k < crc_pkg::CRC_BYTES; k++) begin
			term_q[k] <= term_c[k];
		end
		remainder_q <= remainder_c;
		fold_q      <= i_tail_fold;
	end

	always_comb begin
		merge_c = remainder_q ^ fold_q;
		for (int k = 0; k < crc_pkg::CRC_BYTES; k++) begin
			merge_c ^= term_q[k];
		end
	end

	// step 2
	always_ff @(posedge i_clk) begin
		o_crc <= merge_c;
	end

	always_ff @(posedge i_clk) begin
		if (!i_areset_n) begin
			valid_q     <= 1'b0;
			o_crc_valid <= 1'b0;
		end else begin
			valid_q     <= i_tail_valid;
			o_crc_valid <= valid_q;
		end
	end

endmodule

`default_nettype wire

/* hw/crc256_top.sv */
`default_nettype none

module crc256_top (
	input  wire logic                i_clk,
	input  wire logic                i_areset_n,
	input  wire crc_pkg::data_beat_t i_data,
	input  wire crc_pkg::beat_tag_t  i_tag,
	input  wire logic                i_sop,
	input  wire logic                i_eop,
	output wire crc_pkg::data_beat_t o_data,
	output wire crc_pkg::beat_tag_t  o_tag,
	output wire logic                o_sop,
	output wire logic                o_eop,
	output wire crc_pkg::crc_t       o_crc,
	output wire logic                o_crc_valid
);

	// folder -> accumulator
	crc_pkg::crc_t        fold;
	crc_pkg::byte_count_t fold_count;

	// accumulator -> tail merge
	logic                 tail_valid;
	crc_pkg::crc_t        prev_state;
	crc_pkg::crc_t        tail_fold;
	crc_pkg::byte_count_t tail_count;

	// 3 cycles, beat and control also leave here
	crc_beat_folder u_folder (
		.i_clk      (i_clk),
		.i_areset_n (i_areset_n),
		.i_data     (i_data),
		.i_tag      (i_tag),
		.i_sop      (i_sop),
		.i_eop      (i_eop),
		.o_fold     (fold),
		.o_count    (fold_count),
		.o_sop      (o_sop),
		.o_eop      (o_eop),
		.o_data     (o_data),
		.o_tag      (o_tag)
	);

	// 1 cycle
	crc_accumulator u_accum (
		.i_clk        (i_clk),
		.i_areset_n   (i_areset_n),
		.i_fold       (fold),
		.i_count      (fold_count),
		.i_sop        (o_sop),
		.i_eop        (o_eop),
		.o_tail_valid (tail_valid),
		.o_prev_state (prev_state),
		.o_tail_fold  (tail_fold),
		.o_tail_count (tail_count)
	);

	// 2 cycles
	crc_tail_merge u_tail (
		.i_clk        (i_clk),
		.i_areset_n   (i_areset_n),
		.i_tail_valid (tail_valid),
		.i_prev_state (prev_state),
		.i_tail_fold  (tail_fold),
		.i_tail_count (tail_count),
		.o_crc        (o_crc),
		.o_crc_valid  (o_crc_valid)
	);

endmodule

`default_nettype wire

/* tb/crc256_chk.sv */
`default_nettype none

module crc256_chk (
	input wire logic i_clk,
	input wire logic i_areset_n,
	input wire logic i_sop,
	input wire logic i_eop,
	input wire logic o_sop,
	input wire logic o_crc_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	valid_known: assert property (@(posedge i_clk) disable iff (!i_areset_n)
		!$isunknown(o_crc_valid))
		else $error("o_crc_valid is unknown");

	// folder 3 + accumulator 1 + tail merge 2
	valid_after_eop: assert property (@(posedge i_clk) disable iff (!i_areset_n)
		o_crc_valid |-> $past(i_eop, 6))
		else $error("o_crc_valid without i_eop six cycles before");

	sop_delay: assert property (@(posedge i_clk) disable iff (!i_areset_n)
		o_sop == $past(i_sop, 3))
		else $error("o_sop does not follow i_sop by three cycles");

endmodule

bind crc256_top crc256_chk u_chk (.*);

`default_nettype wire

/* tb/crc256_tb.sv */
`default_nettype none

module crc256_tb;
	timeunit 1ns;
	timeprecision 100ps;

	// crc-32 polynomial and start value
	localparam crc_pkg::crc_t REF_POLY = 32'h04C1_1DB7;
	localparam crc_pkg::crc_t REF_INIT = 32'hFFFF_FFFF;
	localparam int PASS_LAT      = 3; // cycles from drive to pass-through outputs
	localparam int CRC_LAT       = 6; // cycles from the eop beat to o_crc_valid
	localparam int DRAIN_TIMEOUT = 200;

	logic                     i_clk = 1'b0;
	logic                     i_areset_n;
	crc_pkg::data_beat_t      i_data;
	crc_pkg::beat_tag_t       i_tag;
	logic                     i_sop;
	logic                     i_eop;
	wire crc_pkg::data_beat_t o_data;
	wire crc_pkg::beat_tag_t  o_tag;
	wire logic                o_sop;
	wire logic                o_eop;
	wire crc_pkg::crc_t       o_crc;
	wire logic                o_crc_valid;

	logic [15:0] lfsr_state = 16'd22883;
	int          cycle_no = 0;

	// expected pass-through, one entry per driven beat
	crc_pkg::data_beat_t pass_data_q[$];
	crc_pkg::beat_tag_t  pass_tag_q[$];
	logic                pass_sop_q[$];
	logic                pass_eop_q[$];
	int                  pass_stamp_q[$];
	// expected crc, one entry per packet
	crc_pkg::crc_t       crc_exp_q[$];
	int                  crc_stamp_q[$];

	crc256_top DUT (
		.i_clk       (i_clk),
		.i_areset_n  (i_areset_n),
		.i_data      (i_data),
		.i_tag       (i_tag),
		.i_sop       (i_sop),
		.i_eop       (i_eop),
		.o_data      (o_data),
		.o_tag       (o_tag),
		.o_sop       (o_sop),
		.o_eop       (o_eop),
		.o_crc       (o_crc),
		.o_crc_valid (o_crc_valid)
	);

	always #2 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cycle_no <= cycle_no + 1;
	end

	// galois lfsr for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return r;
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'(rand_bits(8) % (hi - lo + 1));
	endfunction

	function automatic crc_pkg::data_beat_t rand_beat();
		crc_pkg::data_beat_t d;
		for (int i = 0; i < crc_pkg::BEAT_BYTES; i++)
			d[8*i +: 8] = crc_pkg::byte_t'(rand_bits(8));
		return d;
	endfunction

	// plain shift register crc, msb of each byte first
	function automatic crc_pkg::crc_t ref_crc(input crc_pkg::byte_t msg[$]);
		crc_pkg::crc_t crc;
		logic          fb;
		crc = REF_INIT;
		foreach (msg[i]) begin
			for (int b = 7; b >= 0; b--) begin
				fb  = crc[31] ^ msg[i][b];
				crc = crc << 1;
				if (fb)
					crc = crc ^ REF_POLY;
			end
		end
		return crc;
	endfunction

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_crc(input string name, input crc_pkg::crc_t got,
			input crc_pkg::crc_t exp);
		if (got !== exp)
			stop_with_error($sformatf("MISMATCH %s got 0x%08h expected 0x%08h",
				name, got, exp));
	endtask

	task automatic check_data(input string name, input crc_pkg::data_beat_t got,
			input crc_pkg::data_beat_t exp);
		if (got !== exp)
			stop_with_error($sformatf("MISMATCH %s got 0x%064h expected 0x%064h",
				name, got, exp));
	endtask

	task automatic check_tag(input string name, input crc_pkg::beat_tag_t got,
			input crc_pkg::beat_tag_t exp);
		if (got !== exp)
			stop_with_error($sformatf("MISMATCH %s got 0x%02h expected 0x%02h",
				name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_with_error($sformatf("MISMATCH %s got 0x%0h expected 0x%0h",
				name, got, exp));
	endtask

	task automatic drive_beat(input crc_pkg::data_beat_t data, input crc_pkg::beat_tag_t tag,
			input logic sop, input logic eop);
		@(negedge i_clk);
		i_data = data;
		i_tag  = tag;
		i_sop  = sop;
		i_eop  = eop;
		pass_data_q.push_back(data);
		pass_tag_q.push_back(tag);
		pass_sop_q.push_back(sop);
		pass_eop_q.push_back(eop);
		pass_stamp_q.push_back(cycle_no);
	endtask

	task automatic drive_idle(input int n);
		for (int i = 0; i < n; i++)
			drive_beat(rand_beat(), crc_pkg::beat_tag_t'(rand_bits(5)), 1'b0, 1'b0);
	endtask

	task automatic send_packet(input int nbeats, input crc_pkg::beat_tag_t last_tag);
		crc_pkg::byte_t      msg[$];
		crc_pkg::data_beat_t beat;
		crc_pkg::beat_tag_t  tag;
		logic                last;
		for (int b = 0; b < nbeats; b++) begin
			beat = rand_beat();
			last = (b == nbeats - 1);
			tag  = last ? last_tag : '0; // only the last beat may be short
			for (int i = 0; i < crc_pkg::BEAT_BYTES - int'(tag); i++)
				msg.push_back(beat[crc_pkg::BEAT_BITS - 1 - 8*i -: 8]);
			drive_beat(beat, tag, b == 0, last);
		end
		crc_exp_q.push_back(ref_crc(msg));
		crc_stamp_q.push_back(cycle_no);
	endtask

	task automatic apply_reset();
		i_areset_n = 1'b0;
		repeat (8) @(negedge i_clk);
		check_flag("o_crc_valid", o_crc_valid, 1'b0);
		check_flag("o_sop", o_sop, 1'b0);
		check_flag("o_eop", o_eop, 1'b0);
		i_areset_n = 1'b1;
	endtask

	// compare on the falling edge while the outputs are stable
	always @(negedge i_clk) begin
		if ($isunknown(o_crc_valid)) begin
			stop_with_error("o_crc_valid is unknown");
		end else begin
			if (pass_stamp_q.size() > 0 && cycle_no >= pass_stamp_q[0] + PASS_LAT) begin
				check_data("o_data", o_data, pass_data_q.pop_front());
				check_tag("o_tag", o_tag, pass_tag_q.pop_front());
				check_flag("o_sop", o_sop, pass_sop_q.pop_front());
				check_flag("o_eop", o_eop, pass_eop_q.pop_front());
				void'(pass_stamp_q.pop_front());
			end
			if (o_crc_valid === 1'b1) begin
				if (crc_exp_q.size() == 0)
					stop_with_error("o_crc_valid pulsed with no packet outstanding");
				else if (cycle_no != crc_stamp_q[0] + CRC_LAT)
					stop_with_error($sformatf("o_crc_valid came %0d cycles after eop, not %0d",
						cycle_no - crc_stamp_q[0], CRC_LAT));
				else begin
					void'(crc_stamp_q.pop_front());
					check_crc("o_crc", o_crc, crc_exp_q.pop_front());
				end
			end else if (crc_stamp_q.size() > 0 && cycle_no >= crc_stamp_q[0] + CRC_LAT) begin
				stop_with_error("o_crc_valid never came for a finished packet");
			end
		end
	end

	initial begin
		bit drained;
		i_areset_n = 1'b0;
		i_data     = '0;
		i_tag      = '0;
		i_sop      = 1'b0;
		i_eop      = 1'b0;
		drained    = 1'b0;
		apply_reset();
		drive_idle(10); // no eop yet, so nothing may come out
		send_packet(1, '0);
		repeat (8) begin
			send_packet(rand_range(2, 8), '0);
			drive_idle(rand_range(0, 2));
		end
		for (int t = 1; t < crc_pkg::BEAT_BYTES; t++) begin
			send_packet(1, crc_pkg::beat_tag_t'(t));
			send_packet(rand_range(2, 5), crc_pkg::beat_tag_t'(t));
		end
		repeat (12) send_packet(rand_range(1, 4), crc_pkg::beat_tag_t'(rand_bits(5)));
		repeat (8) send_packet(1, crc_pkg::beat_tag_t'(rand_bits(5)));
		repeat (12) begin
			drive_idle(rand_range(0, 4));
			send_packet(rand_range(1, 6), crc_pkg::beat_tag_t'(rand_bits(5)));
		end
		drive_idle(2);
		for (int i = 0; i < DRAIN_TIMEOUT && !drained; i++) begin
			@(negedge i_clk);
			drained = (crc_exp_q.size() == 0) && (pass_stamp_q.size() == 0);
		end
		if (drained) begin
			$display("TEST PASS");
			$finish;
		end else begin
			stop_with_error("timed out waiting for outstanding CRCs and pass-through beats");
		end
	end

endmodule

`default_nettype wire

/* sim.f */
common/crc_pkg.sv
hw/crc_beat_folder.sv
hw/crc_accumulator.sv
hw/crc_tail_merge.sv
hw/crc256_top.sv
tb/crc256_chk.sv
tb/crc256_tb.sv

/* Bender.yml */
package:
  name: crc256

sources:
  - common/crc_pkg.sv
  - hw/crc_beat_folder.sv
  - hw/crc_accumulator.sv
  - hw/crc_tail_merge.sv
  - hw/crc256_top.sv
  - target: simulation
    files:
      - tb/crc256_chk.sv
      - tb/crc256_tb.sv
